/* verilog/rv_decode_macros.svh */
// Widths and field constants for the RV32I decode stage, included by every file that needs them
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

`define DATA_WIDTH      32          // Instruction and immediate
`define REG_ADDR_WIDTH  5
`define ALU_OP_WIDTH    4           // Alternate bit over funct3
`define LSU_CTRL_WIDTH  4           // Store bit over funct3
`define OPCODE_WIDTH    7

// Immediate field sizes
`define IMM12_WIDTH     12          // I and S immediates
`define SHAMT_WIDTH     5
`define UIMM_LOW_BITS   12          // Zero fill under a U immediate

////////////////////////////////////////
// Instruction field values
////////////////////////////////////////

`define FUNCT7_ALT      7'b0100000  // Selects SUB and SRA

`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SR       3'b101      // SRL or SRA

// Register x0 never causes a hazard
`define REG_ZERO        5'd0

`endif

/* verilog/rv_decode_pkg.sv */
// Enumerated types of the decode stage, pulled into each module by a wildcard import
`include "rv_decode_macros.svh"

package rv_decode_pkg;

  // Major opcodes the decoder understands
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,  // Fence, treated as a no-op
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111
  } opcode_e;

  // Controller states
  typedef enum logic [3:0] {
    ST_OK,
    ST_STALL,
    ST_LOAD_ADDR,
    ST_LOAD_ISSUE,
    ST_LOAD_WAIT,
    ST_STORE_ADDR,
    ST_STORE_ISSUE,
    ST_IDLE,
    ST_ERROR
  } dec_state_e;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_I_SHIFT,
    IMM_S,
    IMM_U
  } imm_sel_e;

  // Alternate bit over funct3
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

endpackage

/* verilog/hazard_detect.sv */
// RAW hazard check that keeps the last destination register and flags matching source fields
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module hazard_detect import rv_decode_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic [`DATA_WIDTH-1:0] instr_i,
  input  logic                   instr_valid_i,
  input  logic                   advance_i,
  output logic                   rs1_hit_o,
  output logic                   rs2_hit_o
);

  logic [`REG_ADDR_WIDTH-1:0] prev_rd_q;
  logic [`REG_ADDR_WIDTH-1:0] rd;
  logic [`REG_ADDR_WIDTH-1:0] rs1;
  logic [`REG_ADDR_WIDTH-1:0] rs2;
  logic                       writes_rd;

  assign rd  = instr_i[11:7];
  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  // Stores and bubbles leave no result behind
  assign writes_rd = instr_valid_i && (opcode_e'(instr_i[`OPCODE_WIDTH-1:0]) != OPC_STORE);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_rd_q <= `REG_ZERO;
    end else if (advance_i) begin
      prev_rd_q <= writes_rd ? rd : `REG_ZERO;
    end
  end

  assign rs1_hit_o = (rs1 != `REG_ZERO) && (rs1 == prev_rd_q);
  assign rs2_hit_o = (rs2 != `REG_ZERO) && (rs2 == prev_rd_q);

endmodule

/* verilog/imm_gen.sv */
// Immediate generator that builds the I, shift, S and U operands and registers the selected one
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module imm_gen import rv_decode_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic [`DATA_WIDTH-1:0] instr_i,
  input  imm_sel_e               imm_sel_i,
  output logic [`DATA_WIDTH-1:0] imm_ext_o,
  output logic                   is_imm_o   // Operand B comes from the immediate
);

  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_shift;
  logic [`DATA_WIDTH-1:0] imm_s;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_d;

  assign imm_i     = {{(`DATA_WIDTH-`IMM12_WIDTH){instr_i[31]}}, instr_i[31:20]};
  // Shift amount is unsigned
  assign imm_shift = {{(`DATA_WIDTH-`SHAMT_WIDTH){1'b0}}, instr_i[24:20]};
  assign imm_s     = {{(`DATA_WIDTH-`IMM12_WIDTH){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u     = {instr_i[31:12], {`UIMM_LOW_BITS{1'b0}}};

  always_comb begin
    case (imm_sel_i)
      IMM_I:       imm_d = imm_i;
      IMM_I_SHIFT: imm_d = imm_shift;
      IMM_S:       imm_d = imm_s;
      IMM_U:       imm_d = imm_u;
      default:     imm_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      is_imm_o <= 1'b0;
    end else begin
      is_imm_o <= (imm_sel_i != IMM_NONE);
    end
  end

  always_ff @(posedge clk_i) begin
    imm_ext_o <= imm_d;
  end

endmodule

/* verilog/op_route.sv */
// Operand router that registers register-file addresses, the ALU operation and the LSU controls
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module op_route import rv_decode_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [`DATA_WIDTH-1:0]    instr_i,
  input  logic [`DATA_WIDTH-1:0]    instr_addr_i,
  input  logic                      rs1_en_i,
  input  logic                      rs2_en_i,
  input  logic                      alu_wb_i,
  input  logic                      lsu_valid_i,
  input  logic                      lsu_is_store_i,
  output logic [`DATA_WIDTH-1:0]    instr_addr_o,
  output logic [`REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [`REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output alu_op_e                   alu_sel_o,
  output logic [`REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                      alu_wb_o,
  output logic                      is_alu_write_o,   // RF write port belongs to the ALU
  output logic                      lsu_ctrl_valid_o,
  output logic [`LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [`REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  opcode_e                    opcode;
  logic [2:0]                 funct3;
  logic [`REG_ADDR_WIDTH-1:0] rd;
  logic                       alt;
  logic                       alt_used;
  logic                       arith;
  logic                       alu_class;
  logic                       alu_active;
  alu_op_e                    alu_op_d;

  assign opcode = opcode_e'(instr_i[`OPCODE_WIDTH-1:0]);
  assign funct3 = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign alt    = (instr_i[31:25] == `FUNCT7_ALT);

  // SUB and SRA in OP, SRAI in OPIMM
  assign alt_used = ((opcode == OPC_OP) && ((funct3 == `FUNCT3_ADD) || (funct3 == `FUNCT3_SR)))
                 || ((opcode == OPC_OP_IMM) && (funct3 == `FUNCT3_SR));

  assign arith     = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);
  assign alu_class = arith || (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
  // Strobes tell a real ALU instruction from a bubble
  assign alu_active = alu_class && (alu_wb_i || rs1_en_i);

  // Loads, stores, LUI and AUIPC all add
  assign alu_op_d = (alu_active && arith) ? alu_op_e'({alt && alt_used, funct3}) : ALU_ADD;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rf_addr_a_o      <= `REG_ZERO;
      rf_addr_b_o      <= `REG_ZERO;
      alu_sel_o        <= ALU_ADD;
      alu_dest_addr_o  <= `REG_ZERO;
      alu_wb_o         <= 1'b0;
      is_alu_write_o   <= 1'b1;
      lsu_ctrl_valid_o <= 1'b0;
      lsu_ctrl_o       <= '0;
      lsu_regdest_o    <= `REG_ZERO;
    end else begin
      rf_addr_a_o      <= rs1_en_i ? instr_i[19:15] : `REG_ZERO;
      rf_addr_b_o      <= rs2_en_i ? instr_i[24:20] : `REG_ZERO;
      alu_sel_o        <= alu_op_d;
      alu_dest_addr_o  <= alu_active ? rd : `REG_ZERO;
      alu_wb_o         <= alu_wb_i;
      is_alu_write_o   <= alu_active;
      lsu_ctrl_valid_o <= lsu_valid_i;
      lsu_ctrl_o       <= lsu_valid_i ? {lsu_is_store_i, funct3} : '0;
      lsu_regdest_o    <= (lsu_valid_i && !lsu_is_store_i) ? rd : `REG_ZERO;  // Load target
    end
  end

  always_ff @(posedge clk_i) begin
    instr_addr_o <= instr_addr_i;
  end

endmodule

/* verilog/decode_ctrl.sv */
// Decode controller FSM that sequences each instruction class and drives ready, stalls and strobes
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module decode_ctrl import rv_decode_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic [`DATA_WIDTH-1:0] instr_i,
  input  logic                   instr_valid_i,
  input  logic                   lsu_read_complete_i,
  input  logic                   rs1_hit_i,          // rs1 equals previous rd
  input  logic                   rs2_hit_i,
  output imm_sel_e               imm_sel_o,
  output logic                   rs1_en_o,
  output logic                   rs2_en_o,
  output logic                   alu_wb_o,
  output logic                   lsu_valid_o,
  output logic                   lsu_is_store_o,
  output logic                   use_pc_o,
  output logic                   advance_o,          // Instruction finishes this cycle
  output logic                   ready_o,
  output logic                   illegal_instr_o
);

  dec_state_e state_q;
  dec_state_e state_d;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic       in_stall;
  logic       is_shift;
  logic       ready_d;
  logic       illegal_d;
  logic       use_pc_d;

  assign opcode   = opcode_e'(instr_i[`OPCODE_WIDTH-1:0]);
  assign funct3   = instr_i[14:12];
  assign in_stall = (state_q == ST_STALL);  // Hit already paid for
  assign is_shift = (funct3 == `FUNCT3_SLL) || (funct3 == `FUNCT3_SR);

  // Pipeline moves on whenever fetch gets ready
  assign advance_o = ready_d;

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////
  always_comb begin
    state_d        = ST_OK;
    ready_d        = 1'b1;
    illegal_d      = 1'b0;
    use_pc_d       = 1'b0;
    imm_sel_o      = IMM_NONE;
    rs1_en_o       = 1'b0;
    rs2_en_o       = 1'b0;
    alu_wb_o       = 1'b0;
    lsu_valid_o    = 1'b0;
    lsu_is_store_o = 1'b0;

    if (!instr_valid_i) begin
      state_d = ST_IDLE;  // Bubble
    end else begin
      case (opcode)
        OPC_OP: begin
          rs1_en_o = 1'b1;
          rs2_en_o = 1'b1;
          if ((rs1_hit_i || rs2_hit_i) && !in_stall) begin
            state_d = ST_STALL;
            ready_d = 1'b0;
          end else begin
            alu_wb_o = 1'b1;
          end
        end
        OPC_OP_IMM: begin
          rs1_en_o  = 1'b1;
          imm_sel_o = is_shift ? IMM_I_SHIFT : IMM_I;
          if (rs1_hit_i && !in_stall) begin
            state_d = ST_STALL;
            ready_d = 1'b0;
          end else begin
            alu_wb_o = 1'b1;
          end
        end
        OPC_LUI: begin
          imm_sel_o = IMM_U;
          alu_wb_o  = 1'b1;
        end
        OPC_AUIPC: begin
          imm_sel_o = IMM_U;
          alu_wb_o  = 1'b1;
          use_pc_d  = 1'b1;  // ALU adds the PC
        end
        OPC_MISC_MEM: begin
          state_d = ST_OK;
        end
        OPC_LOAD: begin
          rs1_en_o = 1'b1;
          case (state_q)
            ST_LOAD_ADDR: begin
              lsu_valid_o = 1'b1;  // Single issue pulse
              ready_d     = 1'b0;
              state_d     = ST_LOAD_ISSUE;
            end
            ST_LOAD_ISSUE, ST_LOAD_WAIT: begin
              ready_d = lsu_read_complete_i;
              state_d = lsu_read_complete_i ? ST_OK : ST_LOAD_WAIT;
            end
            default: begin
              ready_d = 1'b0;
              if (rs1_hit_i && !in_stall) begin
                state_d = ST_STALL;
              end else begin
                imm_sel_o = IMM_I;  // Address is rs1 + offset
                state_d   = ST_LOAD_ADDR;
              end
            end
          endcase
        end
        OPC_STORE: begin
          rs1_en_o       = 1'b1;
          rs2_en_o       = 1'b1;
          lsu_is_store_o = 1'b1;
          if (state_q == ST_STORE_ADDR) begin
            lsu_valid_o = 1'b1;
            state_d     = ST_STORE_ISSUE;
          end else if ((rs1_hit_i || rs2_hit_i) && !in_stall) begin
            state_d = ST_STALL;
            ready_d = 1'b0;
          end else begin
            imm_sel_o = IMM_S;
            ready_d   = 1'b0;
            state_d   = ST_STORE_ADDR;
          end
        end
        default: begin
          // Unknown or SYSTEM opcode, held until fetch replaces it
          illegal_d = 1'b1;
          ready_d   = 1'b0;
          state_d   = ST_ERROR;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q         <= ST_OK;
      ready_o         <= 1'b1;
      illegal_instr_o <= 1'b0;
      use_pc_o        <= 1'b0;
    end else begin
      state_q         <= state_d;
      ready_o         <= ready_d;
      illegal_instr_o <= illegal_d;
      use_pc_o        <= use_pc_d;
    end
  end

endmodule

/* verilog/rv_decoder_top.sv */
// Top level of the RV32I decode stage that connects the controller to the datapath blocks
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module rv_decoder_top import rv_decode_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rstn_i,
  // Fetch side
  input  logic [`DATA_WIDTH-1:0]     instr_i,
  input  logic [`DATA_WIDTH-1:0]     instr_addr_i,
  input  logic                       instr_valid_i,
  output logic [`DATA_WIDTH-1:0]     instr_addr_o,
  output logic                       ready_o,
  output logic                       use_pc_o,
  output logic                       illegal_instr_o,
  // ALU and register file
  output logic                       is_alu_write_o,
  output alu_op_e                    alu_sel_o,
  output logic [`REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                       alu_wb_o,
  output logic [`REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [`REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output logic                       is_imm_o,
  output logic [`DATA_WIDTH-1:0]     imm_ext_o,
  // Load/store unit
  output logic                       lsu_ctrl_valid_o,
  output logic [`LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [`REG_ADDR_WIDTH-1:0] lsu_regdest_o,
  input  logic                       lsu_read_complete_i
);

  imm_sel_e imm_sel;
  logic     rs1_en;
  logic     rs2_en;
  logic     alu_wb;
  logic     lsu_valid;
  logic     lsu_is_store;
  logic     advance;
  logic     rs1_hit;
  logic     rs2_hit;

  decode_ctrl decode_ctrl_i (
    .clk_i               (clk_i),
    .rstn_i              (rstn_i),
    .instr_i             (instr_i),
    .instr_valid_i       (instr_valid_i),
    .lsu_read_complete_i (lsu_read_complete_i),
    .rs1_hit_i           (rs1_hit),
    .rs2_hit_i           (rs2_hit),
    .imm_sel_o           (imm_sel),
    .rs1_en_o            (rs1_en),
    .rs2_en_o            (rs2_en),
    .alu_wb_o            (alu_wb),
    .lsu_valid_o         (lsu_valid),
    .lsu_is_store_o      (lsu_is_store),
    .use_pc_o            (use_pc_o),
    .advance_o           (advance),
    .ready_o             (ready_o),
    .illegal_instr_o     (illegal_instr_o)
  );

  imm_gen imm_gen_i (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .instr_i   (instr_i),
    .imm_sel_i (imm_sel),
    .imm_ext_o (imm_ext_o),
    .is_imm_o  (is_imm_o)
  );

  hazard_detect hazard_detect_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .advance_i     (advance),
    .rs1_hit_o     (rs1_hit),
    .rs2_hit_o     (rs2_hit)
  );

  op_route op_route_i (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_i          (instr_i),
    .instr_addr_i     (instr_addr_i),
    .rs1_en_i         (rs1_en),
    .rs2_en_i         (rs2_en),
    .alu_wb_i         (alu_wb),
    .lsu_valid_i      (lsu_valid),
    .lsu_is_store_i   (lsu_is_store),
    .instr_addr_o     (instr_addr_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .alu_sel_o        (alu_sel_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .is_alu_write_o   (is_alu_write_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

endmodule

/* verification/rv_decoder_properties.sv */
// Concurrent checks on the decode controller timing, bound into decode_ctrl by the testbench
`timescale 1ns/100ps

module rv_decoder_properties import rv_decode_pkg::*; (
  input logic       clk_i,
  input logic       rstn_i,
  input dec_state_e state_i,
  input logic       lsu_valid_i,
  input logic       ready_i
);

  // LSU request is a single pulse
  lsu_valid_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
    lsu_valid_i |=> !lsu_valid_i)
    else $error("lsu_valid stayed high for more than one cycle");

  // One stall per hazard
  stall_once: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_i == ST_STALL) |=> (state_i != ST_STALL))
    else $error("ST_STALL was followed by another ST_STALL");

  ready_after_reset: assert property (@(posedge clk_i)
    $rose(rstn_i) |-> ready_i)
    else $error("ready was low in the first cycle after reset");

endmodule

/* verification/tb_rv_decoder.sv */
// Testbench for the decode stage that replays per-cycle vectors from the data file and checks outputs
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module tb_rv_decoder import rv_decode_pkg::*; ();

  localparam int    CLK_HALF     = 2;    // 4 ns period
  localparam int    RESET_CYCLES = 3;
  localparam int    FIELDS       = 12;   // Tokens per vector line
  localparam int    MAX_VECTORS  = 64;
  localparam string DATA_FILE    = "verification/rv_decoder_testdata.txt";

  // Column positions inside a vector
  localparam int F_TEST  = 0;
  localparam int F_INSTR = 1;
  localparam int F_VALID = 2;
  localparam int F_RDONE = 3;
  localparam int F_READY = 4;
  localparam int F_ILL   = 5;
  localparam int F_WB    = 6;
  localparam int F_SEL   = 7;
  localparam int F_RFA   = 8;
  localparam int F_RFB   = 9;
  localparam int F_IMM   = 10;
  localparam int F_LSU   = 11;

  logic                       clk_i;
  logic                       rstn_i;
  logic [`DATA_WIDTH-1:0]     instr_i;
  logic [`DATA_WIDTH-1:0]     instr_addr_i;
  logic                       instr_valid_i;
  logic                       lsu_read_complete_i;
  logic [`DATA_WIDTH-1:0]     instr_addr_o;
  logic                       ready_o;
  logic                       use_pc_o;
  logic                       illegal_instr_o;
  logic                       is_alu_write_o;
  alu_op_e                    alu_sel_o;
  logic [`REG_ADDR_WIDTH-1:0] alu_dest_addr_o;
  logic                       alu_wb_o;
  logic [`REG_ADDR_WIDTH-1:0] rf_addr_a_o;
  logic [`REG_ADDR_WIDTH-1:0] rf_addr_b_o;
  logic                       is_imm_o;
  logic [`DATA_WIDTH-1:0]     imm_ext_o;
  logic                       lsu_ctrl_valid_o;
  logic [`LSU_CTRL_WIDTH-1:0] lsu_ctrl_o;
  logic [`REG_ADDR_WIDTH-1:0] lsu_regdest_o;

  logic [31:0] vec_mem [0:FIELDS*MAX_VECTORS-1];
  int          num_vectors;
  int          cycle_count = 0;
  int          cycle_limit = 1000;  // Replaced once the vectors are counted

  rv_decoder_top rv_decoder_top_i (.*);

  bind decode_ctrl rv_decoder_properties rv_decoder_properties_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .state_i     (state_q),
    .lsu_valid_i (lsu_valid_o),
    .ready_i     (ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  // Run length guard
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles", cycle_count));
    end
  end

  function automatic string test_name(input logic [31:0] id);
    case (id)
      32'd1:   return "alu";
      32'd2:   return "hazard";
      32'd3:   return "load";
      32'd4:   return "store";
      32'd5:   return "idle_illegal";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_field(input string test, input string field, input int vec,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      fail_run($sformatf("Mismatch in test %s, vector %0d, %s: expected %h, actual %h",
                         test, vec, field, expected, actual));
    end
  endtask

  ////////////////////////////////////////
  // Vector handling
  ////////////////////////////////////////

  task automatic load_vectors();
    $readmemh(DATA_FILE, vec_mem);
    num_vectors = 0;
    // A test id of zero marks the end
    while ((num_vectors < MAX_VECTORS) && (vec_mem[num_vectors*FIELDS + F_TEST] >= 32'd1)
           && (vec_mem[num_vectors*FIELDS + F_TEST] <= 32'd5)) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      fail_run("No test vectors could be read from the data file");
    end
    cycle_limit = 2 * num_vectors + RESET_CYCLES + 4;
  endtask

  task automatic apply_vector(input int vec);
    int base;
    base                = vec * FIELDS;
    instr_i             = vec_mem[base + F_INSTR];
    instr_addr_i        = vec * 4;
    instr_valid_i       = vec_mem[base + F_VALID][0];
    lsu_read_complete_i = vec_mem[base + F_RDONE][0];
  endtask

  // Outputs without a column follow from the instruction and the expected strobes
  task automatic check_derived(input int vec);
    int          base;
    string       name;
    logic [31:0] instr;
    logic [6:0]  opc;
    logic        valid;
    logic        alu_class;
    logic        mem_op;
    logic        lsu_pulse;
    logic        addr_cycle;
    logic [31:0] exp_dest;
    logic [31:0] exp_lsu_ctrl;
    logic [31:0] exp_regdest;
    base      = vec * FIELDS;
    name      = test_name(vec_mem[base + F_TEST]);
    instr     = vec_mem[base + F_INSTR];
    opc       = instr[6:0];
    valid     = vec_mem[base + F_VALID][0];
    alu_class = valid && ((opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI)
                || (opc == OPC_AUIPC));
    mem_op    = valid && ((opc == OPC_LOAD) || (opc == OPC_STORE));
    lsu_pulse = vec_mem[base + F_LSU][0];
    // Address cycle comes right before the LSU pulse
    addr_cycle = mem_op && (vec + 1 < num_vectors) && vec_mem[base + FIELDS + F_LSU][0];

    exp_dest     = alu_class ? 32'(instr[11:7]) : 32'd0;
    exp_lsu_ctrl = '0;
    exp_regdest  = '0;
    if (lsu_pulse) begin
      exp_lsu_ctrl = {28'd0, (opc == OPC_STORE), instr[14:12]};  // Store bit over funct3
      if (opc == OPC_LOAD) begin
        exp_regdest = 32'(instr[11:7]);
      end
    end

    check_field(name, "instr_addr", vec, vec * 4, instr_addr_o);
    check_field(name, "use_pc", vec, 32'(valid && (opc == OPC_AUIPC)), 32'(use_pc_o));
    check_field(name, "is_alu_write", vec, 32'(alu_class), 32'(is_alu_write_o));
    check_field(name, "alu_dest_addr", vec, exp_dest, 32'(alu_dest_addr_o));
    check_field(name, "is_imm", vec, 32'(addr_cycle || (alu_class && (opc != OPC_OP))),
                32'(is_imm_o));
    check_field(name, "lsu_ctrl", vec, exp_lsu_ctrl, 32'(lsu_ctrl_o));
    check_field(name, "lsu_regdest", vec, exp_regdest, 32'(lsu_regdest_o));
  endtask

  task automatic check_vector(input int vec);
    int    base;
    string name;
    base = vec * FIELDS;
    name = test_name(vec_mem[base + F_TEST]);
    check_field(name, "ready", vec, vec_mem[base + F_READY], 32'(ready_o));
    check_field(name, "illegal", vec, vec_mem[base + F_ILL], 32'(illegal_instr_o));
    check_field(name, "alu_wb", vec, vec_mem[base + F_WB], 32'(alu_wb_o));
    check_field(name, "alu_sel", vec, vec_mem[base + F_SEL], 32'(alu_sel_o));
    check_field(name, "rf_addr_a", vec, vec_mem[base + F_RFA], 32'(rf_addr_a_o));
    check_field(name, "rf_addr_b", vec, vec_mem[base + F_RFB], 32'(rf_addr_b_o));
    check_field(name, "imm_ext", vec, vec_mem[base + F_IMM], imm_ext_o);
    check_field(name, "lsu_ctrl_valid", vec, vec_mem[base + F_LSU], 32'(lsu_ctrl_valid_o));
    check_derived(vec);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rstn_i              = 1'b0;
    instr_i             = '0;
    instr_addr_i        = '0;
    instr_valid_i       = 1'b0;
    lsu_read_complete_i = 1'b0;
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    // Outputs of each vector are checked one cycle later
    for (int v = 0; v < num_vectors; v++) begin
      apply_vector(v);
      @(negedge clk_i);
      check_vector(v);
    end

    $display("No errors");
    $finish;
  end

endmodule

/* list.f */
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/hazard_detect.sv
verilog/imm_gen.sv
verilog/op_route.sv
verilog/decode_ctrl.sv
verilog/rv_decoder_top.sv
verification/rv_decoder_properties.sv
verification/tb_rv_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_decoder -f list.f -o sim_rv_decoder \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_rv_decoder | tee /dev/stderr | grep -q "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* verification/rv_decoder_testdata.txt */
// Columns: test instr valid read_complete, then expected ready illegal alu_wb alu_sel
// rf_addr_a rf_addr_b imm_ext lsu_ctrl_valid; test 0 ends the list
// ALU instructions
1 00500093 1 0 1 0 1 0 00 00 00000005 0
1 40335113 1 0 1 0 1 d 06 00 00000003 0
1 00435393 1 0 1 0 1 5 06 00 00000004 0
1 40a48433 1 0 1 0 1 8 09 0a 00000000 0
1 123455b7 1 0 1 0 1 0 00 00 12345000 0
1 fffff617 1 0 1 0 1 0 00 00 fffff000 0
1 005201b3 1 0 1 0 1 0 04 05 00000000 0
// Hazards on rs1, on rs1 of an immediate op, on rs2
2 0051c6b3 1 0 0 0 0 4 03 05 00000000 0
2 0051c6b3 1 0 1 0 1 4 03 05 00000000 0
2 ff06f713 1 0 0 0 0 7 0d 00 fffffff0 0
2 ff06f713 1 0 1 0 1 7 0d 00 fffffff0 0
2 00e0e7b3 1 0 0 0 0 6 01 0e 00000000 0
2 00e0e7b3 1 0 1 0 1 6 01 0e 00000000 0
// Load with two wait cycles
3 00812803 1 0 0 0 0 0 02 00 00000008 0
3 00812803 1 0 0 0 0 0 02 00 00000000 1
3 00812803 1 0 0 0 0 0 02 00 00000000 0
3 00812803 1 0 0 0 0 0 02 00 00000000 0
3 00812803 1 1 1 0 0 0 02 00 00000000 0
// Use of the load result
2 00180893 1 0 0 0 0 0 10 00 00000001 0
2 00180893 1 0 1 0 1 0 10 00 00000001 0
// Stores with positive and negative offset
4 00522623 1 0 0 0 0 0 04 05 0000000c 0
4 00522623 1 0 1 0 0 0 04 05 00000000 1
4 fe63ae23 1 0 0 0 0 0 07 06 fffffffc 0
4 fe63ae23 1 0 1 0 0 0 07 06 00000000 1
// Bubbles, fence, illegal opcodes and recovery
5 005201b3 0 0 1 0 0 0 00 00 00000000 0
5 00000000 0 0 1 0 0 0 00 00 00000000 0
1 0ff0000f 1 0 1 0 0 0 00 00 00000000 0
5 00000073 1 0 0 1 0 0 00 00 00000000 0
5 00000073 1 0 0 1 0 0 00 00 00000000 0
5 0000007f 1 0 0 1 0 0 00 00 00000000 0
5 00000000 0 0 1 0 0 0 00 00 00000000 0
1 00500093 1 0 1 0 1 0 00 00 00000005 0
0 00000000 0 0 0 0 0 0 00 00 00000000 0
